/* bp_defines.svh */
`ifndef BP_DEFINES_SVH
`define BP_DEFINES_SVH

// byte address width of every pc seen by the predictor
`define BP_PC_W   10

// set index comes from the low pc bits
`define BP_SET_W  4

// 16 sets in the table
`define BP_SETS   (1 << `BP_SET_W)

// four ways per set
`define BP_WAYS   4

// way index and fifo pointer width
`define BP_WAY_W  2

// tag is the part of the pc above the set index
`define BP_TAG_W  (`BP_PC_W - `BP_SET_W)

// 2-bit saturating counter per line
`define BP_CTR_W  2

`endif

/* bp_table_pkg.sv */
`include "bp_defines.svh"

package bp_table_pkg;

	// one table line of 19 bits
	// field order from msb is valid then tag then target then counter
	typedef struct packed {
		logic                 valid;
		logic [`BP_TAG_W-1:0] tag;
		logic [`BP_PC_W-1:0]  target;
		logic [`BP_CTR_W-1:0] ctr;
	} bht_entry_t;

	// all ways of one set side by side
	typedef bht_entry_t [`BP_WAYS-1:0] bht_set_t;

	// result of one combinational lookup
	// entry reads as all zero on a miss
	typedef struct packed {
		logic                 hit;
		logic [`BP_WAY_W-1:0] way;
		bht_entry_t           entry;
	} bht_lookup_t;

	// counter write from exe
	typedef struct packed {
		logic                 en;
		logic [`BP_SET_W-1:0] set;
		logic [`BP_WAY_W-1:0] way;
		logic [`BP_CTR_W-1:0] ctr;
	} bht_update_t;

	// upper pc bits form the tag
	function automatic logic [`BP_TAG_W-1:0] pc_tag(input logic [`BP_PC_W-1:0] pc);
		return pc[`BP_PC_W-1:`BP_SET_W];
	endfunction

	// low pc bits pick the set
	function automatic logic [`BP_SET_W-1:0] pc_set(input logic [`BP_PC_W-1:0] pc);
		return pc[`BP_SET_W-1:0];
	endfunction

endpackage

/* bp_ctrl_pkg.sv */
`include "bp_defines.svh"

package bp_ctrl_pkg;

	// one-hot branch kind from decode
	// bit order follows the exe btype level, beq on the msb
	typedef enum logic [5:0] {
		BR_NONE = 6'b000000,
		BR_BGEU = 6'b000001,
		BR_BLTU = 6'b000010,
		BR_BGE  = 6'b000100,
		BR_BLT  = 6'b001000,
		BR_BNE  = 6'b010000,
		BR_BEQ  = 6'b100000
	} br_type_e;

	// saturating counter states
	// msb set means predict taken
	typedef enum logic [`BP_CTR_W-1:0] {
		CTR_STRONG_NT = 2'b00,
		CTR_WEAK_NT   = 2'b01,
		CTR_WEAK_T    = 2'b10,
		CTR_STRONG_T  = 2'b11
	} ctr_state_e;

	// where the next fetch pc comes from
	typedef enum logic [1:0] {
		PC_SEQ     = 2'b00,
		PC_IF_PBT  = 2'b01,
		PC_EXE_CNI = 2'b10,
		PC_EXE_PBT = 2'b11
	} pc_sel_e;

endpackage

/* bht_table.sv */
`timescale 1ns/1ps

`include "bp_defines.svh"

module bht_table
	import bp_table_pkg::*;
	import bp_ctrl_pkg::*;
(
	input  logic                CLK,
	input  logic                arst_n,

	// if lookup address
	input  logic [`BP_PC_W-1:0] if_pc,

	// exe lookup address
	input  logic [`BP_PC_W-1:0] exe_pc,

	// id allocation request
	input  logic [`BP_PC_W-1:0] id_pc,
	input  logic [`BP_PC_W-1:0] id_target,
	input  logic                id_is_jump,
	input  logic                id_is_btype,

	// counter write from the resolver
	input  bht_update_t         upd,

	// combinational lookup results
	output bht_lookup_t         if_look,
	output bht_lookup_t         exe_look
);

	// 16 sets of 4 lines
	bht_set_t bht_mem [`BP_SETS];

	// per set fifo replacement pointer
	logic [`BP_WAY_W-1:0] fifo_ptr [`BP_SETS];

	// id side lookup and allocation
	bht_lookup_t          id_look;
	logic [`BP_SET_W-1:0] id_set;
	logic                 alloc_en;
	logic [`BP_WAY_W-1:0] alloc_way;
	logic [`BP_WAY_W-1:0] alloc_next;
	ctr_state_e           alloc_ctr;
	bht_entry_t           alloc_entry;

	// exe write loses to an allocation on the same line
	logic                 upd_blocked;

	// tag compare across the ways of one set
	// first valid match wins, ways never hold the same tag twice
	function automatic bht_lookup_t lookup(
		input bht_set_t            ways,
		input logic [`BP_PC_W-1:0] pc
	);
		bht_lookup_t res;
		res = '0;
		for (int w = 0; w < `BP_WAYS; w++) begin
			if (!res.hit && ways[w].valid && (ways[w].tag == pc_tag(pc))) begin
				res.hit   = 1'b1;
				res.way   = w[`BP_WAY_W-1:0];
				res.entry = ways[w];
			end
		end
		return res;
	endfunction

	// if port
	assign if_look  = lookup(bht_mem[pc_set(if_pc)], if_pc);

	// exe port
	assign exe_look = lookup(bht_mem[pc_set(exe_pc)], exe_pc);

	// id needs its own compare to decide on allocation
	assign id_set  = pc_set(id_pc);
	assign id_look = lookup(bht_mem[id_set], id_pc);

	// allocate only for a jump or branch that misses
	assign alloc_en = (id_is_jump || id_is_btype) && !id_look.hit;

	// victim is the oldest line of the set
	assign alloc_way  = fifo_ptr[id_set];

	// pointer wraps modulo 4
	assign alloc_next = alloc_way + `BP_WAY_W'(1);

	// jumps start strongly taken
	// conditional branches start weakly not taken
	assign alloc_ctr = id_is_jump ? CTR_STRONG_T : CTR_WEAK_NT;

	always_comb begin
		alloc_entry.valid  = 1'b1;
		alloc_entry.tag    = pc_tag(id_pc);
		alloc_entry.target = id_target;
		alloc_entry.ctr    = alloc_ctr;
	end

	// same set and way as the new line
	assign upd_blocked = alloc_en
		&& (upd.set == id_set)
		&& (upd.way == alloc_way);

	// table and pointer state
	// writes land on the edge and show up in lookups next cycle
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			for (int s = 0; s < `BP_SETS; s++) begin
				bht_mem[s]  <= '0;
				fifo_ptr[s] <= '0;
			end
		end else begin
			// exe training touches only the counter field
			if (upd.en && !upd_blocked) begin
				bht_mem[upd.set][upd.way].ctr <= upd.ctr;
			end
			// whole line replaced on allocation
			if (alloc_en) begin
				bht_mem[id_set][alloc_way] <= alloc_entry;
				fifo_ptr[id_set]           <= alloc_next;
			end
		end
	end

endmodule

/* branch_resolver.sv */
`timescale 1ns/1ps

`include "bp_defines.svh"

module branch_resolver
	import bp_table_pkg::*;
	import bp_ctrl_pkg::*;
(
	// exe stage inputs
	input  logic [`BP_PC_W-1:0] exe_pc,
	input  logic                exe_z,
	input  logic                exe_less,
	input  br_type_e            exe_btype,
	input  bht_lookup_t         exe_look,

	// if stage view for the next pc
	input  logic [`BP_PC_W-1:0] if_pc,
	input  logic                if_prediction,
	input  logic [`BP_PC_W-1:0] if_pbt,

	// counter write back to the table
	output bht_update_t         upd,

	// correction and redirect
	output logic [1:0]          exe_correction,
	output logic                flush,
	output logic [`BP_PC_W-1:0] exe_pbt,
	output logic [`BP_PC_W-1:0] exe_cni,
	output logic [`BP_PC_W-1:0] next_pc
);

	// instructions are 4 bytes
	localparam logic [`BP_PC_W-1:0] INSN_BYTES = `BP_PC_W'(4);

	logic       is_branch;
	logic       br_taken;
	logic       pred_taken;
	ctr_state_e ctr_cur;
	ctr_state_e ctr_next;
	pc_sel_e    pc_sel;

	// actual outcome from the flags
	always_comb begin
		is_branch = 1'b1;
		case (exe_btype)
			BR_BEQ:  br_taken = exe_z;
			BR_BNE:  br_taken = !exe_z;
			BR_BLT,
			BR_BLTU: br_taken = exe_less;
			BR_BGE,
			BR_BGEU: br_taken = !exe_less;
			default: begin
				// no branch in exe, nothing to resolve
				is_branch = 1'b0;
				br_taken  = 1'b0;
			end
		endcase
	end

	// stored prediction
	// a miss counts as predicted not taken
	assign pred_taken = exe_look.hit && exe_look.entry.ctr[`BP_CTR_W-1];

	// 10 means fall through to cni
	// 11 means redirect to pbt
	always_comb begin
		exe_correction = 2'b00;
		if (is_branch && pred_taken && !br_taken) begin
			exe_correction = 2'b10;
		end else if (is_branch && !pred_taken && br_taken) begin
			exe_correction = 2'b11;
		end
	end

	assign flush = exe_correction[1];

	// target reads as zero on a miss
	assign exe_pbt = exe_look.entry.target;

	// instruction after the branch
	assign exe_cni = exe_pc + INSN_BYTES;

	// saturating up on taken, down on not taken
	assign ctr_cur = ctr_state_e'(exe_look.entry.ctr);

	always_comb begin
		case (ctr_cur)
			CTR_STRONG_NT: ctr_next = br_taken ? CTR_WEAK_NT  : CTR_STRONG_NT;
			CTR_WEAK_NT:   ctr_next = br_taken ? CTR_WEAK_T   : CTR_STRONG_NT;
			CTR_WEAK_T:    ctr_next = br_taken ? CTR_STRONG_T : CTR_WEAK_NT;
			default:       ctr_next = br_taken ? CTR_STRONG_T : CTR_WEAK_T;
		endcase
	end

	// train only lines that are in the table
	always_comb begin
		upd.en  = is_branch && exe_look.hit;
		upd.set = pc_set(exe_pc);
		upd.way = exe_look.way;
		upd.ctr = ctr_next;
	end

	// exe correction beats the if prediction
	always_comb begin
		if (exe_correction == 2'b11) begin
			pc_sel = PC_EXE_PBT;
		end else if (exe_correction == 2'b10) begin
			pc_sel = PC_EXE_CNI;
		end else if (if_prediction) begin
			pc_sel = PC_IF_PBT;
		end else begin
			pc_sel = PC_SEQ;
		end
	end

	always_comb begin
		case (pc_sel)
			PC_EXE_PBT: next_pc = exe_pbt;
			PC_EXE_CNI: next_pc = exe_cni;
			PC_IF_PBT:  next_pc = if_pbt;
			default:    next_pc = if_pc + INSN_BYTES;
		endcase
	end

endmodule

/* branch_predictor.sv */
`timescale 1ns/1ps

`include "bp_defines.svh"

module branch_predictor
	import bp_table_pkg::*;
	import bp_ctrl_pkg::*;
(
	input  logic                CLK,
	input  logic                arst_n,

	// fetch
	input  logic [`BP_PC_W-1:0] if_pc,

	// decode
	input  logic [`BP_PC_W-1:0] id_pc,
	input  logic [`BP_PC_W-1:0] id_target,
	input  logic                id_is_jump,
	input  logic                id_is_btype,

	// execute
	input  logic [`BP_PC_W-1:0] exe_pc,
	input  logic                exe_z,
	input  logic                exe_less,
	input  br_type_e            exe_btype,

	// prediction back to fetch
	output logic                if_prediction,
	output logic [`BP_PC_W-1:0] if_pbt,

	// resolution results
	output logic [1:0]          exe_correction,
	output logic [`BP_PC_W-1:0] exe_pbt,
	output logic [`BP_PC_W-1:0] exe_cni,
	output logic                flush,
	output logic [`BP_PC_W-1:0] next_pc
);

	bht_lookup_t if_look;
	bht_lookup_t exe_look;
	bht_update_t upd;

	// storage with if and exe read ports
	bht_table u_table (
		.CLK         (CLK),
		.arst_n      (arst_n),
		.if_pc       (if_pc),
		.exe_pc      (exe_pc),
		.id_pc       (id_pc),
		.id_target   (id_target),
		.id_is_jump  (id_is_jump),
		.id_is_btype (id_is_btype),
		.upd         (upd),
		.if_look     (if_look),
		.exe_look    (exe_look)
	);

	// predict taken only on a hit with the counter msb set
	assign if_prediction = if_look.hit && if_look.entry.ctr[`BP_CTR_W-1];
	assign if_pbt        = if_look.entry.target;

	// outcome check, training and next pc
	branch_resolver u_resolver (
		.exe_pc         (exe_pc),
		.exe_z          (exe_z),
		.exe_less       (exe_less),
		.exe_btype      (exe_btype),
		.exe_look       (exe_look),
		.if_pc          (if_pc),
		.if_prediction  (if_prediction),
		.if_pbt         (if_pbt),
		.upd            (upd),
		.exe_correction (exe_correction),
		.flush          (flush),
		.exe_pbt        (exe_pbt),
		.exe_cni        (exe_cni),
		.next_pc        (next_pc)
	);

endmodule

/* tb_branch_predictor.sv */
`timescale 1ns/1ps

`include "bp_defines.svh"

module tb_branch_predictor
	import bp_table_pkg::*;
	import bp_ctrl_pkg::*;
();

	localparam int CLK_HALF   = 20;
	localparam int MAX_CYCLES = 200;

	// dut inputs
	logic                CLK;
	logic                arst_n;
	logic [`BP_PC_W-1:0] if_pc;
	logic [`BP_PC_W-1:0] id_pc;
	logic [`BP_PC_W-1:0] id_target;
	logic                id_is_jump;
	logic                id_is_btype;
	logic [`BP_PC_W-1:0] exe_pc;
	logic                exe_z;
	logic                exe_less;
	br_type_e            exe_btype;

	// dut outputs
	logic                if_prediction;
	logic [`BP_PC_W-1:0] if_pbt;
	logic [1:0]          exe_correction;
	logic [`BP_PC_W-1:0] exe_pbt;
	logic [`BP_PC_W-1:0] exe_cni;
	logic                flush;
	logic [`BP_PC_W-1:0] next_pc;

	// reference model of the table
	bht_entry_t           model_mem [`BP_SETS][`BP_WAYS];
	logic [`BP_WAY_W-1:0] model_ptr [`BP_SETS];
	bht_lookup_t          m_exe;
	bht_lookup_t          m_id;
	logic                 m_alloc;
	logic [`BP_SET_W-1:0] m_id_set;
	logic [`BP_SET_W-1:0] m_exe_set;

	int seed;
	int err_count;
	int test_err;
	int pass_count;
	int fail_count;

	branch_predictor dut (.*);

	initial begin
		CLK = 1'b0;
		forever #(CLK_HALF) CLK = ~CLK;
	end

	// watchdog on the whole run
	initial begin
		for (int c = 0; c < MAX_CYCLES; c++) begin
			@(posedge CLK);
		end
		$display("timeout, run did not finish within %0d cycles", MAX_CYCLES);
		$display("Checks failed");
		$finish;
	end

	// tag match over the model ways, miss reads as zero
	function automatic bht_lookup_t model_look(input logic [`BP_PC_W-1:0] pc);
		bht_lookup_t res;
		bht_entry_t  e;
		res = '0;
		for (int w = 0; w < `BP_WAYS; w++) begin
			e = model_mem[pc[`BP_SET_W-1:0]][w];
			if (!res.hit && e.valid && (e.tag == pc[`BP_PC_W-1:`BP_SET_W])) begin
				res.hit   = 1'b1;
				res.way   = 2'(w);
				res.entry = e;
			end
		end
		return res;
	endfunction

	// branch outcome from flags
	function automatic logic outcome(input br_type_e bt, input logic z, input logic less);
		case (bt)
			BR_BEQ:  return z;
			BR_BNE:  return !z;
			BR_BLT:  return less;
			BR_BLTU: return less;
			BR_BGE:  return !less;
			BR_BGEU: return !less;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic [`BP_CTR_W-1:0] saturate(input logic [1:0] c, input logic taken);
		if (taken) begin
			return (c == 2'd3) ? c : c + 2'd1;
		end
		return (c == 2'd0) ? c : c - 2'd1;
	endfunction

	// pcs that share set 9 with distinct tags
	function automatic logic [`BP_PC_W-1:0] fifo_pc(input int k);
		return {`BP_TAG_W'(k + 1), 4'h9};
	endfunction

	// model state moves on the same edge as the dut
	always @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			for (int s = 0; s < `BP_SETS; s++) begin
				for (int w = 0; w < `BP_WAYS; w++) begin
					model_mem[s][w] = '0;
				end
				model_ptr[s] = '0;
			end
		end else begin
			// both lookups see the state before this edge
			m_exe     = model_look(exe_pc);
			m_id      = model_look(id_pc);
			m_id_set  = id_pc[`BP_SET_W-1:0];
			m_exe_set = exe_pc[`BP_SET_W-1:0];
			m_alloc   = (id_is_jump || id_is_btype) && !m_id.hit;
			if ((exe_btype != BR_NONE) && m_exe.hit) begin
				// allocation on the same line wins
				if (!(m_alloc && (m_exe_set == m_id_set)
					&& (m_exe.way == model_ptr[m_id_set]))) begin
					model_mem[m_exe_set][m_exe.way].ctr =
						saturate(m_exe.entry.ctr, outcome(exe_btype, exe_z, exe_less));
				end
			end
			if (m_alloc) begin
				model_mem[m_id_set][model_ptr[m_id_set]] = '{
					valid:  1'b1,
					tag:    id_pc[`BP_PC_W-1:`BP_SET_W],
					target: id_target,
					ctr:    id_is_jump ? CTR_STRONG_T : CTR_WEAK_NT
				};
				model_ptr[m_id_set] = model_ptr[m_id_set] + 2'd1;
			end
		end
	end

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
			err_count++;
			test_err++;
		end
	endtask

	task automatic check_pc(input string name, input logic [`BP_PC_W-1:0] got,
		input logic [`BP_PC_W-1:0] exp);
		if (got !== exp) begin
			$display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
			err_count++;
			test_err++;
		end
	endtask

	task automatic check_corr(input string name, input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp) begin
			$display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
			err_count++;
			test_err++;
		end
	endtask

	task automatic report_test(input string name);
		if (test_err == 0) begin
			$display("PASS %s", name);
			pass_count++;
		end else begin
			$display("FAIL %s with %0d errors", name, test_err);
			fail_count++;
		end
		test_err = 0;
	endtask

	// inputs change 2 ns after the edge
	task automatic tick();
		@(posedge CLK);
		#2;
	endtask

	// combinational outputs settled
	task automatic settle();
		#5;
	endtask

	task automatic drive_idle();
		id_is_jump  = 1'b0;
		id_is_btype = 1'b0;
		exe_btype   = BR_NONE;
		exe_z       = 1'b0;
		exe_less    = 1'b0;
	endtask

	// every output against the model for the current inputs
	task automatic check_all();
		bht_lookup_t         il;
		bht_lookup_t         el;
		logic                ifp;
		logic                pred;
		logic                tk;
		logic [1:0]          corr;
		logic [`BP_PC_W-1:0] nxt;
		il   = model_look(if_pc);
		el   = model_look(exe_pc);
		ifp  = il.hit && il.entry.ctr[1];
		pred = el.hit && el.entry.ctr[1];
		tk   = outcome(exe_btype, exe_z, exe_less);
		if ((exe_btype == BR_NONE) || (pred == tk)) begin
			corr = 2'b00;
		end else begin
			corr = pred ? 2'b10 : 2'b11;
		end
		if (corr == 2'b11) begin
			nxt = el.entry.target;
		end else if (corr == 2'b10) begin
			nxt = exe_pc + 10'd4;
		end else begin
			nxt = ifp ? il.entry.target : if_pc + 10'd4;
		end
		check_bit("if_prediction", if_prediction, ifp);
		check_pc("if_pbt", if_pbt, il.entry.target);
		check_corr("exe_correction", exe_correction, corr);
		check_bit("flush", flush, corr[1]);
		check_pc("exe_pbt", exe_pbt, el.entry.target);
		check_pc("exe_cni", exe_cni, exe_pc + 10'd4);
		check_pc("next_pc", next_pc, nxt);
	endtask

	// keep resolving one branch until the if prediction turns
	task automatic resolve_until(input logic [`BP_PC_W-1:0] pc, input logic taken,
		input int max_steps, output int steps);
		logic done;
		steps = 0;
		done  = 1'b0;
		while (!done) begin
			drive_idle();
			exe_pc    = pc;
			if_pc     = pc;
			exe_btype = BR_BEQ;
			exe_z     = taken;
			settle();
			check_all();
			if (if_prediction === taken) begin
				done = 1'b1;
			end else if (steps >= max_steps) begin
				$display("if_prediction did not turn to %0d within %0d resolutions",
					taken, max_steps);
				err_count++;
				test_err++;
				done = 1'b1;
			end else begin
				steps++;
			end
			tick();
		end
	endtask

	task automatic test_after_reset();
		for (int i = 0; i < 8; i++) begin
			drive_idle();
			if_pc    = `BP_PC_W'($random(seed));
			exe_pc   = `BP_PC_W'($random(seed));
			// flags mean nothing without a branch in exe
			exe_z    = 1'($random(seed));
			exe_less = 1'($random(seed));
			settle();
			check_bit("if_prediction", if_prediction, 1'b0);
			check_corr("exe_correction", exe_correction, 2'b00);
			check_bit("flush", flush, 1'b0);
			check_pc("next_pc", next_pc, if_pc + 10'd4);
			tick();
		end
		report_test("after reset");
	endtask

	task automatic test_allocation();
		// jump into set 4
		drive_idle();
		id_pc      = 10'h104;
		id_target  = 10'h2a0;
		id_is_jump = 1'b1;
		settle();
		check_all();
		tick();
		// branch into set 8 while if reads the jump
		drive_idle();
		id_pc       = 10'h0c8;
		id_target   = 10'h050;
		id_is_btype = 1'b1;
		if_pc       = 10'h104;
		settle();
		check_all();
		check_bit("if_prediction", if_prediction, 1'b1);
		check_pc("if_pbt", if_pbt, 10'h2a0);
		tick();
		drive_idle();
		if_pc = 10'h0c8;
		settle();
		check_all();
		check_bit("if_prediction", if_prediction, 1'b0);
		check_pc("next_pc", next_pc, 10'h0cc);
		tick();
		report_test("allocation");
	endtask

	task automatic test_outcome();
		for (int i = 0; i < 6; i++) begin
			for (int f = 0; f < 2; f++) begin
				drive_idle();
				exe_pc    = 10'h0c8;
				if_pc     = 10'h3f0;
				exe_btype = br_type_e'(6'(1 << i));
				// z and less driven apart so each type sees its own flag
				exe_z     = f[0];
				exe_less  = !f[0];
				settle();
				check_all();
				tick();
			end
		end
		report_test("outcome rule");
	endtask

	task automatic test_training();
		int steps;
		drive_idle();
		id_pc       = 10'h1a5;
		id_target   = 10'h300;
		id_is_btype = 1'b1;
		settle();
		check_all();
		tick();
		// weak not taken already predicts not taken
		// the one not-taken resolution drops it to strong not taken
		resolve_until(10'h1a5, 1'b0, 4, steps);
		if (steps != 0) begin
			$display("not taken after %0d resolutions instead of 0", steps);
			err_count++;
			test_err++;
		end
		// strong not taken needs two taken updates
		resolve_until(10'h1a5, 1'b1, 4, steps);
		if (steps != 2) begin
			$display("taken after %0d resolutions instead of 2", steps);
			err_count++;
			test_err++;
		end
		// saturated at strong taken
		for (int i = 0; i < 3; i++) begin
			drive_idle();
			exe_pc    = 10'h1a5;
			if_pc     = 10'h1a5;
			exe_btype = BR_BEQ;
			exe_z     = 1'b1;
			settle();
			check_all();
			check_bit("if_prediction", if_prediction, 1'b1);
			tick();
		end
		resolve_until(10'h1a5, 1'b0, 4, steps);
		if (steps != 2) begin
			$display("not taken after %0d resolutions instead of 2", steps);
			err_count++;
			test_err++;
		end
		report_test("saturating training");
	endtask

	task automatic test_fifo();
		for (int k = 0; k < 5; k++) begin
			drive_idle();
			id_pc      = fifo_pc(k);
			id_target  = fifo_pc(k) + 10'h100;
			id_is_jump = 1'b1;
			settle();
			check_all();
			tick();
		end
		// fifth tag replaced the first
		for (int k = 0; k < 5; k++) begin
			drive_idle();
			if_pc = fifo_pc(k);
			settle();
			check_all();
			check_bit("if_prediction", if_prediction, k != 0);
			if (k != 0) begin
				check_pc("if_pbt", if_pbt, fifo_pc(k) + 10'h100);
			end
			tick();
		end
		report_test("fifo replacement");
	endtask

	task automatic test_next_pc();
		// if jump hit and exe taken correction together
		drive_idle();
		if_pc     = 10'h104;
		exe_pc    = 10'h1a5;
		exe_btype = BR_BEQ;
		exe_z     = 1'b1;
		settle();
		check_all();
		check_bit("if_prediction", if_prediction, 1'b1);
		check_corr("exe_correction", exe_correction, 2'b11);
		check_pc("next_pc", next_pc, 10'h300);
		tick();
		drive_idle();
		if_pc = 10'h104;
		settle();
		check_all();
		check_pc("next_pc", next_pc, 10'h2a0);
		tick();
		report_test("next pc priority");
	endtask

	initial begin
		seed       = 54;
		err_count  = 0;
		test_err   = 0;
		pass_count = 0;
		fail_count = 0;
		arst_n     = 1'b0;
		if_pc      = '0;
		id_pc      = '0;
		id_target  = '0;
		exe_pc     = '0;
		drive_idle();
		for (int c = 0; c < 5; c++) begin
			@(posedge CLK);
		end
		#2;
		arst_n = 1'b1;
		test_after_reset();
		test_allocation();
		test_outcome();
		test_training();
		test_fifo();
		test_next_pc();
		$display("tests passed %0d failed %0d, check errors %0d",
			pass_count, fail_count, err_count);
		if ((fail_count == 0) && (err_count == 0)) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

/* tb.f */
+incdir+.
bp_table_pkg.sv
bp_ctrl_pkg.sv
bht_table.sv
branch_resolver.sv
branch_predictor.sv
tb_branch_predictor.sv

/* Makefile */
# Verilator build and run for the branch predictor testbench

VERILATOR ?= verilator
TOP       ?= tb_branch_predictor
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed
VFLAGS    ?= --binary --timing

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

# result comes from the log, not from the simulator exit status
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation result: pass"; \
	else \
		echo "simulation result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
